// File: common/lc3b_types.sv
package lc3b_types;

// basic widths
typedef logic [15:0] lc3b_word;
typedef logic [2:0]  lc3b_reg;
typedef logic [2:0]  lc3b_nzp;
typedef logic [3:0]  lc3b_opcode;
typedef logic [1:0]  lc3b_aluop;

// opcodes of the supported subset
localparam lc3b_opcode op_br  = 4'b0000;
localparam lc3b_opcode op_add = 4'b0001;
localparam lc3b_opcode op_and = 4'b0101;
localparam lc3b_opcode op_ldr = 4'b0110;
localparam lc3b_opcode op_str = 4'b0111;
localparam lc3b_opcode op_not = 4'b1001;
localparam lc3b_opcode op_jmp = 4'b1100;

// alu operations
localparam lc3b_aluop alu_add  = 2'b00;
localparam lc3b_aluop alu_and  = 2'b01;
localparam lc3b_aluop alu_not  = 2'b10;
localparam lc3b_aluop alu_pass = 2'b11;

typedef struct packed {
    lc3b_opcode opcode;
    lc3b_aluop  aluop;
    // 0 picks sr2 data, 1 picks the immediate
    logic       sr2mux_sel;
    logic       load_regfile;
    logic       load_cc;
    logic       mem_read;
    logic       mem_write;
    // 0 picks alu result, 1 picks memory data
    logic       regfilemux_sel;
    logic       br;
    logic       jmp;
} lc3b_control_word;

typedef struct packed {
    logic     valid;
    lc3b_word pc;
    lc3b_word instruction;
} if_id_t;

typedef struct packed {
    logic             valid;
    lc3b_control_word ctrl;
    lc3b_word         pc;
    lc3b_reg          dest;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;
    lc3b_word         imm;
    lc3b_word         offset;
} id_ex_t;

typedef struct packed {
    logic             valid;
    lc3b_control_word ctrl;
    lc3b_reg          dest;
    lc3b_word         alu;
    lc3b_word         pc_br;
    lc3b_word         sr1_data;
    lc3b_word         store_data;
    lc3b_nzp          nzp;
} ex_mem_t;

typedef struct packed {
    logic             valid;
    lc3b_control_word ctrl;
    lc3b_reg          dest;
    lc3b_word         value;
} mem_wb_t;

endpackage : lc3b_types

// File: datapath/fetch_stage.sv
module fetch_stage #(
    parameter lc3b_types::lc3b_word start_pc = 16'h0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 br_en,
    input  logic                 jmp,
    input  lc3b_types::lc3b_word pc_br,
    input  lc3b_types::lc3b_word sr1_data,
    input  logic                 resp_a,
    input  lc3b_types::lc3b_word rdata_a,
    output logic                 read_a,
    output lc3b_types::lc3b_word address_a,
    output lc3b_types::if_id_t   if_out
);
    import lc3b_types::*;

    // hold keeps an instruction that arrived while port B was busy
    typedef enum logic [1:0] {
        f_idle,
        f_req,
        f_hold
    } fetch_state_t;

    fetch_state_t state;
    lc3b_word     pc;
    lc3b_word     pc_plus2;
    lc3b_word     pc_next;
    lc3b_word     inst_buf;

    assign pc_plus2  = pc + 16'd2;
    assign read_a    = (state == f_req);
    assign address_a = pc;

    // redirect from the memory stage wins over sequential fetch
    always_comb begin
        if (br_en) begin
            pc_next = pc_br;
        end else if (jmp) begin
            pc_next = sr1_data;
        end else begin
            pc_next = pc_plus2;
        end
    end

    always_comb begin
        if_out.valid       = (state == f_hold) | ((state == f_req) & resp_a);
        if_out.pc          = pc_plus2;
        if_out.instruction = (state == f_hold) ? inst_buf : rdata_a;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= f_idle;
            pc    <= start_pc;
        end else begin
            case (state)
                f_idle: state <= f_req;
                f_req: begin
                    if (!stall) begin
                        pc <= pc_next;
                    end else if (resp_a) begin
                        state <= f_hold;
                    end
                end
                f_hold: begin
                    if (!stall) begin
                        pc    <= pc_next;
                        state <= f_req;
                    end
                end
                default: state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == f_req) && resp_a) begin
            inst_buf <= rdata_a;
        end
    end

endmodule : fetch_stage

// File: datapath/decode_stage.sv
module decode_stage (
    input  lc3b_types::if_id_t   if_in,
    input  lc3b_types::lc3b_word sr1_data,
    input  lc3b_types::lc3b_word sr2_data,
    output lc3b_types::lc3b_reg  sr1,
    output lc3b_types::lc3b_reg  sr2,
    output lc3b_types::id_ex_t   id_out
);
    import lc3b_types::*;

    lc3b_opcode       opcode;
    lc3b_control_word ctrl;
    logic             is_mem;
    lc3b_word         imm5_sext;
    lc3b_word         off6_sext;
    lc3b_word         off9_sext;

    assign opcode = if_in.instruction[15:12];
    assign is_mem = (opcode == op_ldr) || (opcode == op_str);

    // base register and first alu source share bits 8:6
    assign sr1 = if_in.instruction[8:6];
    // STR reads its source register from the dest field
    assign sr2 = (opcode == op_str) ? if_in.instruction[11:9] : if_in.instruction[2:0];

    assign imm5_sext = {{11{if_in.instruction[4]}}, if_in.instruction[4:0]};
    assign off6_sext = {{10{if_in.instruction[5]}}, if_in.instruction[5:0]};
    assign off9_sext = {{7{if_in.instruction[8]}}, if_in.instruction[8:0]};

    // a bubble or an unknown opcode becomes a NOP
    always_comb begin
        ctrl        = '0;
        ctrl.opcode = opcode;
        ctrl.aluop  = alu_pass;
        case (opcode)
            op_add, op_and: begin
                ctrl.aluop        = (opcode == op_add) ? alu_add : alu_and;
                ctrl.sr2mux_sel   = if_in.instruction[5];
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_not: begin
                ctrl.aluop        = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
            end
            op_ldr: begin
                ctrl.aluop          = alu_add;
                ctrl.sr2mux_sel     = 1'b1;
                ctrl.mem_read       = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
                ctrl.regfilemux_sel = 1'b1;
            end
            op_str: begin
                ctrl.aluop      = alu_add;
                ctrl.sr2mux_sel = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            op_br:  ctrl.br = 1'b1;
            op_jmp: ctrl.jmp = 1'b1;
            default: ctrl.opcode = op_br;
        endcase
        if (!if_in.valid) begin
            ctrl        = '0;
            ctrl.opcode = op_br;
            ctrl.aluop  = alu_pass;
        end
    end

    always_comb begin
        id_out.valid    = if_in.valid;
        id_out.ctrl     = ctrl;
        id_out.pc       = if_in.pc;
        id_out.dest     = if_in.instruction[11:9];
        id_out.sr1_data = sr1_data;
        id_out.sr2_data = sr2_data;
        id_out.imm      = is_mem ? off6_sext : imm5_sext;
        id_out.offset   = off9_sext;
    end

endmodule : decode_stage

// File: datapath/regfile.sv
module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_word data,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word sr1_data,
    output lc3b_types::lc3b_word sr2_data
);
    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= data;
        end
    end

    // write-through so decode sees a value retiring this cycle
    assign sr1_data = (load && (dest == sr1)) ? data : regs[sr1];
    assign sr2_data = (load && (dest == sr2)) ? data : regs[sr2];

endmodule : regfile

// File: datapath/execute_stage.sv
module execute_stage (
    input  lc3b_types::id_ex_t  id_in,
    output lc3b_types::ex_mem_t ex_out
);
    import lc3b_types::*;

    logic     scale;
    lc3b_word operand_b;
    lc3b_word alu_out;

    // LDR and STR offsets count words
    assign scale = (id_in.ctrl.opcode == op_ldr) || (id_in.ctrl.opcode == op_str);

    always_comb begin
        if (!id_in.ctrl.sr2mux_sel) begin
            operand_b = id_in.sr2_data;
        end else if (scale) begin
            operand_b = {id_in.imm[14:0], 1'b0};
        end else begin
            operand_b = id_in.imm;
        end
    end

    always_comb begin
        case (id_in.ctrl.aluop)
            alu_add: alu_out = id_in.sr1_data + operand_b;
            alu_and: alu_out = id_in.sr1_data & operand_b;
            alu_not: alu_out = ~id_in.sr1_data;
            default: alu_out = id_in.sr1_data;
        endcase
    end

    always_comb begin
        ex_out.valid      = id_in.valid;
        ex_out.ctrl       = id_in.ctrl;
        ex_out.dest       = id_in.dest;
        ex_out.alu        = alu_out;
        // pc is already pc + 2 here
        ex_out.pc_br      = id_in.pc + {id_in.offset[14:0], 1'b0};
        ex_out.sr1_data   = id_in.sr1_data;
        ex_out.store_data = id_in.sr2_data;
        ex_out.nzp        = id_in.dest;
    end

endmodule : execute_stage

// File: datapath/memory_stage.sv
module memory_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  lc3b_types::ex_mem_t  ex_in,
    input  logic                 resp_b,
    input  lc3b_types::lc3b_word rdata_b,
    output logic                 read_b,
    output logic                 write_b,
    output lc3b_types::lc3b_word address_b,
    output lc3b_types::lc3b_word wdata_b,
    output logic                 br_en,
    output lc3b_types::mem_wb_t  wb_out
);
    import lc3b_types::*;

    // set once port B has answered but the pipeline is still held
    logic     done;
    lc3b_word data_buf;
    lc3b_word mem_data;
    lc3b_word wb_value;
    lc3b_nzp  cc;
    lc3b_nzp  cc_next;

    assign read_b    = ex_in.valid & ex_in.ctrl.mem_read & ~done;
    assign write_b   = ex_in.valid & ex_in.ctrl.mem_write & ~done;
    assign address_b = ex_in.alu;
    assign wdata_b   = ex_in.store_data;

    assign mem_data = done ? data_buf : rdata_b;
    assign wb_value = ex_in.ctrl.regfilemux_sel ? mem_data : ex_in.alu;

    always_comb begin
        if (wb_value[15]) begin
            cc_next = 3'b100;
        end else if (wb_value == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    assign br_en = ex_in.valid & ex_in.ctrl.br & (|(ex_in.nzp & cc));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
            cc   <= 3'b010;
        end else if (!stall) begin
            done <= 1'b0;
            if (ex_in.valid && ex_in.ctrl.load_cc) begin
                cc <= cc_next;
            end
        end else if (resp_b) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_b) begin
            data_buf <= rdata_b;
        end
    end

    always_comb begin
        wb_out.valid = ex_in.valid;
        wb_out.ctrl  = ex_in.ctrl;
        wb_out.dest  = ex_in.dest;
        wb_out.value = wb_value;
    end

endmodule : memory_stage

// File: hdl/cpu_datapath.sv
module cpu_datapath #(
    parameter lc3b_types::lc3b_word start_pc = 16'h0000
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // port A for instruction reads
    input  logic                 resp_a,
    input  lc3b_types::lc3b_word rdata_a,
    output logic                 read_a,
    output lc3b_types::lc3b_word address_a,

    // port B for data
    input  logic                 resp_b,
    input  lc3b_types::lc3b_word rdata_b,
    output logic                 read_b,
    output logic                 write_b,
    output lc3b_types::lc3b_word address_b,
    output lc3b_types::lc3b_word wdata_b
);
    import lc3b_types::*;

    logic     stall;
    logic     br_en;
    logic     load_regfile;
    lc3b_reg  sr1;
    lc3b_reg  sr2;
    lc3b_word sr1_data;
    lc3b_word sr2_data;

    // combinational stage outputs
    if_id_t   if_stage;
    id_ex_t   id_stage;
    ex_mem_t  ex_stage;
    mem_wb_t  mem_stage;

    // pipeline registers
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    // any port still waiting for resp freezes the whole pipe
    assign stall = (read_a & ~resp_a) | ((read_b | write_b) & ~resp_b);

    assign load_regfile = mem_wb.valid & mem_wb.ctrl.load_regfile;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (!stall) begin
            if_id  <= if_stage;
            id_ex  <= id_stage;
            ex_mem <= ex_stage;
            mem_wb <= mem_stage;
        end
    end

    fetch_stage #(
        .start_pc(start_pc)
    ) fetch_stage_i (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .br_en(br_en),
        .jmp(ex_mem.ctrl.jmp),
        .pc_br(ex_mem.pc_br),
        .sr1_data(ex_mem.sr1_data),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .read_a(read_a),
        .address_a(address_a),
        .if_out(if_stage)
    );

    decode_stage decode_stage_i (
        .if_in(if_id),
        .sr1_data(sr1_data),
        .sr2_data(sr2_data),
        .sr1(sr1),
        .sr2(sr2),
        .id_out(id_stage)
    );

    // written from the writeback register
    regfile regfile_i (
        .clk(clk),
        .rst_n(rst_n),
        .load(load_regfile),
        .dest(mem_wb.dest),
        .data(mem_wb.value),
        .sr1(sr1),
        .sr2(sr2),
        .sr1_data(sr1_data),
        .sr2_data(sr2_data)
    );

    execute_stage execute_stage_i (
        .id_in(id_ex),
        .ex_out(ex_stage)
    );

    memory_stage memory_stage_i (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .ex_in(ex_mem),
        .resp_b(resp_b),
        .rdata_b(rdata_b),
        .read_b(read_b),
        .write_b(write_b),
        .address_b(address_b),
        .wdata_b(wdata_b),
        .br_en(br_en),
        .wb_out(mem_stage)
    );

endmodule : cpu_datapath

// File: verification/cpu_mem_model.sv
module cpu_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 read_a,
    input  lc3b_types::lc3b_word address_a,
    output logic                 resp_a,
    output lc3b_types::lc3b_word rdata_a,
    input  logic                 read_b,
    input  logic                 write_b,
    input  lc3b_types::lc3b_word address_b,
    input  lc3b_types::lc3b_word wdata_b,
    output logic                 resp_b,
    output lc3b_types::lc3b_word rdata_b
);
    import lc3b_types::*;

    // 32K words cover the whole byte address space
    lc3b_word mem [32768];
    integer   seed = 32'he7b2_fa3d;
    logic     busy_a;
    logic     busy_b;
    int       left_a;
    int       left_b;
    int       lat;

    initial begin
        resp_a  = 1'b0;
        resp_b  = 1'b0;
        rdata_a = '0;
        rdata_b = '0;
        busy_a  = 1'b0;
        busy_b  = 1'b0;
        left_a  = 0;
        left_b  = 0;
    end

    // latency of 1 to 4 cycles drawn anew per request
    always @(negedge clk) begin
        if (!rst_n) begin
            resp_a <= 1'b0;
            busy_a <= 1'b0;
        end else if (resp_a) begin
            resp_a <= 1'b0;
        end else if (read_a) begin
            lat = busy_a ? left_a : {$random(seed)} % 4;
            if (lat == 0) begin
                resp_a  <= 1'b1;
                rdata_a <= mem[address_a[15:1]];
                busy_a  <= 1'b0;
            end else begin
                busy_a <= 1'b1;
                left_a <= lat - 1;
            end
        end
        if (!rst_n) begin
            resp_b <= 1'b0;
            busy_b <= 1'b0;
        end else if (resp_b) begin
            resp_b <= 1'b0;
        end else if (read_b || write_b) begin
            lat = busy_b ? left_b : {$random(seed)} % 4;
            if (lat == 0) begin
                resp_b <= 1'b1;
                busy_b <= 1'b0;
                if (write_b) begin
                    mem[address_b[15:1]] <= wdata_b;
                end else begin
                    rdata_b <= mem[address_b[15:1]];
                end
            end else begin
                busy_b <= 1'b1;
                left_b <= lat - 1;
            end
        end
    end

endmodule : cpu_mem_model

// File: verification/cpu_props.sv
module cpu_props (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 read_b,
    input logic                 write_b,
    input logic                 resp_b,
    input lc3b_types::lc3b_word address_b,
    input lc3b_types::lc3b_word wdata_b
);

    one_request: assert property (
        @(posedge clk) disable iff (!rst_n) !(read_b && write_b)
    ) else $error("read_b and write_b are high together");

    // a waiting request keeps its address and data
    request_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (read_b || write_b) && !resp_b |=> $stable(address_b) && $stable(wdata_b)
    ) else $error("port B address or data changed while waiting for resp_b");

    idle_in_reset: assert property (
        @(posedge clk) !rst_n |-> !read_b && !write_b
    ) else $error("port B request active during reset");

endmodule : cpu_props

bind cpu_datapath cpu_props cpu_props_i (.*);

// File: verification/cpu_tb.sv
module cpu_tb;
    import lc3b_types::*;

    localparam lc3b_word start_pc = 16'h0100;
    localparam int max_lat = 4;

    logic     clk;
    logic     rst_n;
    logic     resp_a;
    logic     resp_b;
    logic     read_a;
    logic     read_b;
    logic     write_b;
    lc3b_word rdata_a;
    lc3b_word rdata_b;
    lc3b_word address_a;
    lc3b_word address_b;
    lc3b_word wdata_b;

    lc3b_word image [32768];
    lc3b_word ref_mem [32768];
    lc3b_word exp_addr [$];
    lc3b_word exp_data [$];
    lc3b_word pc_at;
    lc3b_word loop_addr;
    lc3b_word jmp_target;
    lc3b_word jmp_slot;
    lc3b_word last_fetch;
    logic     jmp_seen;
    logic     check_jmp;
    int       tbl_n;
    int       errors;
    int       budget;
    int       prog_cycles;
    string    prog_name;

    cpu_datapath #(
        .start_pc(start_pc)
    ) cpu_datapath_i (
        .clk(clk),
        .rst_n(rst_n),
        .resp_a(resp_a),
        .rdata_a(rdata_a),
        .read_a(read_a),
        .address_a(address_a),
        .resp_b(resp_b),
        .rdata_b(rdata_b),
        .read_b(read_b),
        .write_b(write_b),
        .address_b(address_b),
        .wdata_b(wdata_b)
    );

    cpu_mem_model mem_model_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction encoders
    function automatic lc3b_word op_rr(lc3b_opcode op, lc3b_reg d, lc3b_reg s1, lc3b_reg s2);
        return {op, d, s1, 3'b000, s2};
    endfunction

    function automatic lc3b_word op_ri(lc3b_opcode op, lc3b_reg d, lc3b_reg s1, int imm);
        return {op, d, s1, 1'b1, imm[4:0]};
    endfunction

    function automatic lc3b_word mem_op(lc3b_opcode op, lc3b_reg r, lc3b_reg base, int off);
        return {op, r, base, off[5:0]};
    endfunction

    function automatic lc3b_word br_op(lc3b_nzp nzp, int off);
        return {op_br, nzp, off[8:0]};
    endfunction

    function automatic lc3b_word not_op(lc3b_reg d, lc3b_reg s);
        return {op_not, d, s, 6'b111111};
    endfunction

    function automatic lc3b_word jmp_op(lc3b_reg base);
        return {op_jmp, 3'b000, base, 6'b000000};
    endfunction

    // every instruction gets three NOPs, covering hazards and delay slots
    task automatic put(input lc3b_word w);
        image[pc_at[15:1]] = w;
        pc_at = pc_at + 16'd2;
        repeat (3) begin
            image[pc_at[15:1]] = '0;
            pc_at = pc_at + 16'd2;
        end
    endtask

    // constants sit in a table at word 0 and load through R0
    task automatic load_const(input lc3b_reg r, input lc3b_word v);
        image[tbl_n] = v;
        put(mem_op(op_ldr, r, 3'd0, tbl_n));
        tbl_n++;
    endtask

    task automatic begin_program(input string name);
        int i;
        prog_name = name;
        for (i = 0; i < 32768; i++) begin
            image[i] = lc3b_word'(i) * 16'h9e37 ^ {i[7:0], i[15:8]};
        end
        pc_at     = start_pc;
        tbl_n     = 0;
        check_jmp = 1'b0;
    endtask

    task automatic end_program();
        loop_addr = pc_at;
        put(br_op(3'b111, -1));
    endtask

    // ISA-level model with three delay slots after a taken branch or jump
    function automatic void interpret_program();
        lc3b_word r [8];
        lc3b_nzp  cc;
        lc3b_word pc;
        lc3b_word npc;
        lc3b_word tgt;
        lc3b_word new_tgt;
        lc3b_word inst;
        lc3b_word val;
        lc3b_word opb;
        lc3b_word addr;
        logic     taken;
        logic     wr;
        int       slots;
        int       steps;
        int       i;
        for (i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        for (i = 0; i < 32768; i++) begin
            ref_mem[i] = image[i];
        end
        exp_addr.delete();
        exp_data.delete();
        cc    = 3'b010;
        pc    = start_pc;
        tgt   = '0;
        slots = 0;
        steps = 0;
        while (pc != loop_addr && steps < 100000) begin
            inst    = ref_mem[pc[15:1]];
            taken   = 1'b0;
            wr      = 1'b0;
            val     = '0;
            new_tgt = '0;
            npc     = pc + 16'd2;
            opb     = inst[5] ? {{11{inst[4]}}, inst[4:0]} : r[inst[2:0]];
            addr    = r[inst[8:6]] + {{9{inst[5]}}, inst[5:0], 1'b0};
            case (inst[15:12])
                4'b0001: begin
                    val = r[inst[8:6]] + opb;
                    wr  = 1'b1;
                end
                4'b0101: begin
                    val = r[inst[8:6]] & opb;
                    wr  = 1'b1;
                end
                4'b1001: begin
                    val = ~r[inst[8:6]];
                    wr  = 1'b1;
                end
                4'b0110: begin
                    val = ref_mem[addr[15:1]];
                    wr  = 1'b1;
                end
                4'b0111: begin
                    ref_mem[addr[15:1]] = r[inst[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[inst[11:9]]);
                end
                4'b0000: begin
                    taken   = |(inst[11:9] & cc);
                    new_tgt = pc + 16'd2 + {{6{inst[8]}}, inst[8:0], 1'b0};
                end
                4'b1100: begin
                    taken   = 1'b1;
                    new_tgt = r[inst[8:6]];
                end
                default: ;
            endcase
            if (wr) begin
                r[inst[11:9]] = val;
                cc = val[15] ? 3'b100 : (val == '0) ? 3'b010 : 3'b001;
            end
            if (slots > 0) begin
                slots--;
                if (slots == 0) begin
                    npc = tgt;
                end
            end
            if (taken) begin
                tgt   = new_tgt;
                slots = 3;
            end
            pc = npc;
            steps++;
        end
    endfunction

    task automatic run_program();
        int i;
        int loop_hits;
        interpret_program();
        @(negedge clk);
        rst_n = 1'b0;
        for (i = 0; i < 32768; i++) begin
            mem_model_i.mem[i] = image[i];
        end
        budget      = 40 * ((loop_addr - start_pc) / 2 + 4) * max_lat;
        prog_cycles = 0;
        repeat (3) @(negedge clk);
        jmp_seen = 1'b0;
        rst_n    = 1'b1;
        do @(negedge clk); while (!read_a);
        assert (address_a == start_pc && !read_b && !write_b) else begin
            $display("ERR %0t: first fetch at %h with read_b %b write_b %b",
                     $time, address_a, read_b, write_b);
            errors++;
        end
        loop_hits = 0;
        while (loop_hits < 2) begin
            @(posedge clk);
            if (read_a && resp_a && address_a == loop_addr) begin
                loop_hits++;
            end
        end
        assert (exp_addr.size() == 0) else begin
            $display("program %s ended with %0d expected stores missing",
                     prog_name, exp_addr.size());
            errors++;
        end
        if (check_jmp) begin
            assert (jmp_seen) else begin
                $display("program %s did not fetch the jump target after the delay slots",
                         prog_name);
                errors++;
            end
        end
    endtask

    task automatic build_alu();
        begin_program("alu");
        load_const(3'd1, 16'h1234);
        load_const(3'd2, 16'h8f0f);
        load_const(3'd6, 16'h4000);
        put(op_rr(op_add, 3'd3, 3'd1, 3'd2));
        put(mem_op(op_str, 3'd3, 3'd6, 0));
        put(op_ri(op_add, 3'd3, 3'd1, -7));
        put(mem_op(op_str, 3'd3, 3'd6, 1));
        put(op_rr(op_and, 3'd3, 3'd1, 3'd2));
        put(mem_op(op_str, 3'd3, 3'd6, 2));
        put(op_ri(op_and, 3'd3, 3'd2, 11));
        put(mem_op(op_str, 3'd3, 3'd6, 3));
        put(not_op(3'd3, 3'd2));
        put(mem_op(op_str, 3'd3, 3'd6, 4));
        put(op_ri(op_add, 3'd4, 3'd2, 15));
        put(mem_op(op_str, 3'd4, 3'd6, 5));
        end_program();
    endtask

    task automatic build_copy();
        int k;
        begin_program("copy");
        load_const(3'd6, 16'h4100);
        load_const(3'd5, 16'h5000);
        for (k = 0; k < 8; k++) begin
            put(mem_op(op_ldr, 3'd3, 3'd6, k));
            put(mem_op(op_str, 3'd3, 3'd5, k));
        end
        put(mem_op(op_ldr, 3'd3, 3'd6, -3));
        put(mem_op(op_str, 3'd3, 3'd5, -1));
        end_program();
    endtask

    // each BR skips one STR group when taken
    task automatic build_branch();
        int res;
        int mask;
        int k;
        begin_program("branch");
        load_const(3'd6, 16'h6000);
        k = 0;
        for (res = 0; res < 3; res++) begin
            case (res)
                0: put(op_ri(op_add, 3'd3, 3'd0, 5));
                1: put(op_ri(op_and, 3'd3, 3'd0, 0));
                default: put(not_op(3'd3, 3'd0));
            endcase
            for (mask = 1; mask < 8; mask++) begin
                put(br_op(mask[2:0], 7));
                put(mem_op(op_str, 3'd3, 3'd6, k));
                k++;
            end
        end
        end_program();
    endtask

    task automatic build_jmp();
        int t;
        begin_program("jmp");
        load_const(3'd6, 16'h7000);
        t = tbl_n;
        load_const(3'd4, 16'h0000);
        // last delay slot of the jump
        jmp_slot = pc_at + 16'd6;
        put(jmp_op(3'd4));
        put(mem_op(op_str, 3'd4, 3'd6, 0));
        put(mem_op(op_str, 3'd4, 3'd6, 1));
        jmp_target = pc_at;
        image[t]   = pc_at;
        put(mem_op(op_str, 3'd4, 3'd6, 2));
        end_program();
        check_jmp = 1'b1;
    endtask

    // the target must be the fetch right after the last delay slot
    always @(posedge clk) begin
        if (rst_n && read_a && resp_a) begin
            if (address_a == jmp_target && last_fetch == jmp_slot) begin
                jmp_seen <= 1'b1;
            end
            last_fetch <= address_a;
        end
    end

    // store checker against the reference list
    always @(posedge clk) begin
        if (rst_n && write_b && resp_b) begin
            assert (exp_addr.size() > 0) else begin
                $display("program %s made an unexpected store of %h to %h",
                         prog_name, wdata_b, address_b);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                assert (address_b == exp_addr[0] && wdata_b == exp_data[0]) else begin
                    $display("ERR %0t: store %h to %h, expected %h to %h", $time,
                             wdata_b, address_b, exp_data[0], exp_addr[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    // watchdog with a budget per program
    always @(posedge clk) begin
        prog_cycles++;
        if (prog_cycles > budget) begin
            $display("timeout in program %s after %0d cycles", prog_name, prog_cycles);
            $display("errors: %0d", errors + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rst_n       = 1'b0;
        errors      = 0;
        budget      = 100000;
        prog_cycles = 0;
        jmp_seen    = 1'b0;
        check_jmp   = 1'b0;
        jmp_target  = 16'hffff;
        jmp_slot    = 16'hffff;
        last_fetch  = 16'hffff;
        prog_name   = "none";
        build_alu();
        run_program();
        build_copy();
        run_program();
        build_branch();
        run_program();
        build_jmp();
        run_program();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : cpu_tb

// File: list.f
common/lc3b_types.sv
datapath/fetch_stage.sv
datapath/decode_stage.sv
datapath/regfile.sv
datapath/execute_stage.sv
datapath/memory_stage.sv
hdl/cpu_datapath.sv
verification/cpu_mem_model.sv
verification/cpu_props.sv
verification/cpu_tb.sv
